//--- design/trap_pkg.sv
// Trap unit shared definitions
`default_nettype none

package trap_pkg;

  // Data and PC width
  localparam int XLEN = 32;

  // Retire buffer geometry
  localparam int FIFO_DEPTH = 4;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);

  // MCAUSE layout has the interrupt flag in bit 31 and the code in the low bits
  localparam int CAUSE_W      = 5;
  localparam int MCAUSE_PAD_W = XLEN - CAUSE_W - 1;

  //////////////////////////////////////////////////////////////
  // Exception codes
  //////////////////////////////////////////////////////////////

  localparam logic [CAUSE_W-1:0] EXC_CAUSE_INSTR_FAULT     = 5'd1;
  localparam logic [CAUSE_W-1:0] EXC_CAUSE_ILLEGAL_INSN    = 5'd2;
  localparam logic [CAUSE_W-1:0] EXC_CAUSE_BREAKPOINT      = 5'd3;
  localparam logic [CAUSE_W-1:0] EXC_CAUSE_ECALL_MMODE     = 5'd11;
  localparam logic [CAUSE_W-1:0] EXC_CAUSE_INSTR_BUS_FAULT = 5'd24;

  // Number of fault flags carried by a retiring instruction
  localparam int NUM_EXC = 5;

  // Cause priority, highest first: MPU fault, bus fault, illegal, ECALL, EBREAK
  // Entry k holds the code of the flag at bit k of the packed flag vector
  localparam logic [CAUSE_W-1:0] EXC_PRIO_CODE [NUM_EXC] = '{
    EXC_CAUSE_INSTR_FAULT,
    EXC_CAUSE_INSTR_BUS_FAULT,
    EXC_CAUSE_ILLEGAL_INSN,
    EXC_CAUSE_ECALL_MMODE,
    EXC_CAUSE_BREAKPOINT
  };

  // Packs the five flags so that bit 0 is the most urgent one
  function automatic logic [NUM_EXC-1:0] exc_flags(input logic mpu_err, input logic bus_err,
                                                   input logic illegal, input logic ecall,
                                                   input logic ebrk);
    return {ebrk, ecall, illegal, bus_err, mpu_err};
  endfunction

  // Lowest set flag wins, zero when the instruction is clean
  function automatic logic [CAUSE_W-1:0] exc_cause(input logic [NUM_EXC-1:0] flags);
    logic [CAUSE_W-1:0] cause;
    cause = '0;
    for (int k = NUM_EXC - 1; k >= 0; k--) begin
      if (flags[k]) begin
        cause = EXC_PRIO_CODE[k];
      end
    end
    return cause;
  endfunction

endpackage

`default_nettype wire

//--- design/retire_decode.sv
// Retire stream cause encoder
`default_nettype none

module retire_decode
  import trap_pkg::*;
(
  input  logic               clk,
  input  logic               rst_ni,

  // Retirement stream from the core
  input  logic               in_valid_i,
  input  logic [XLEN-1:0]    in_pc_i,
  input  logic               in_mpu_err_i,
  input  logic               in_bus_err_i,
  input  logic               in_illegal_i,
  input  logic               in_ecall_i,
  input  logic               in_ebrk_i,

  // Buffer level, a strobe seen while this is high is lost
  input  logic               full_i,

  // Write side of the retire buffer
  output logic               push_o,
  output logic [XLEN-1:0]    push_pc_o,
  output logic               push_exc_o,
  output logic [CAUSE_W-1:0] push_cause_o
);

  //////////////////////////////////////////////////////////////
  // Cause resolution
  //////////////////////////////////////////////////////////////

  logic [NUM_EXC-1:0] flags;

  // Bit 0 is the MPU fault, so the encoder walks the vector from the bottom
  assign flags = exc_flags(in_mpu_err_i, in_bus_err_i, in_illegal_i, in_ecall_i, in_ebrk_i);

  // The entry is captured by the buffer at the edge that closes the strobe cycle,
  // which keeps the strobe-to-head cost at a single cycle
  assign push_o       = in_valid_i && !full_i;
  assign push_pc_o    = in_pc_i;
  assign push_exc_o   = |flags;
  assign push_cause_o = exc_cause(flags);

  //////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////

  // An MPU fault outranks every other flag in the cause encoding
  a_mpu_fault_first :
    assert property (@(posedge clk) disable iff (!rst_ni)
                     (push_o && in_mpu_err_i) |-> (push_cause_o == EXC_CAUSE_INSTR_FAULT))
      else $error("retire_decode: MPU fault lost to a lower priority flag");

endmodule

`default_nettype wire

//--- design/retire_fifo.sv
// Retire entry buffer
`default_nettype none

module retire_fifo
  import trap_pkg::*;
(
  input  logic               clk,
  input  logic               rst_ni,

  // Write side
  input  logic               push_i,
  input  logic [XLEN-1:0]    push_pc_i,
  input  logic               push_exc_i,
  input  logic [CAUSE_W-1:0] push_cause_i,

  // Read side, the head is visible combinationally
  input  logic               pop_i,
  output logic               full_o,
  output logic               head_valid_o,
  output logic [XLEN-1:0]    head_pc_o,
  output logic               head_exc_o,
  output logic [CAUSE_W-1:0] head_cause_o
);

  // Entry storage
  logic [XLEN-1:0]    pc_mem    [FIFO_DEPTH];
  logic               exc_mem   [FIFO_DEPTH];
  logic [CAUSE_W-1:0] cause_mem [FIFO_DEPTH];

  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [CNT_W-1:0]   count_q;
  logic               wr_en;
  logic               rd_en;

  // Advance a pointer with wrap at the last slot
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o       = (count_q == CNT_W'(FIFO_DEPTH));
  assign head_valid_o = (count_q != '0);
  assign head_pc_o    = pc_mem[rd_ptr_q];
  assign head_exc_o   = exc_mem[rd_ptr_q];
  assign head_cause_o = cause_mem[rd_ptr_q];

  // Requests are qualified so that a bad request cannot corrupt the pointers
  assign wr_en = push_i && !full_o;
  assign rd_en = pop_i && head_valid_o;

  //////////////////////////////////////////////////////////////
  // Pointers and fill level
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (rd_en) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // Simultaneous push and pop leaves the level unchanged
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      pc_mem[wr_ptr_q]    <= push_pc_i;
      exc_mem[wr_ptr_q]   <= push_exc_i;
      cause_mem[wr_ptr_q] <= push_cause_i;
    end
  end

  //////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////

  a_no_pop_when_empty :
    assert property (@(posedge clk) disable iff (!rst_ni) pop_i |-> head_valid_o)
      else $error("retire_fifo: pop while empty");

  a_no_push_when_full :
    assert property (@(posedge clk) disable iff (!rst_ni) push_i |-> !full_o)
      else $error("retire_fifo: push while full");

endmodule

`default_nettype wire

//--- design/trap_csr.sv
// Machine-mode trap CSRs
`default_nettype none

module trap_csr
  import trap_pkg::*;
(
  input  logic               clk,
  input  logic               rst_ni,

  // Head of the retire buffer
  input  logic               head_valid_i,
  input  logic [XLEN-1:0]    head_pc_i,
  input  logic               head_exc_i,
  input  logic [CAUSE_W-1:0] head_cause_i,

  // Interrupt lines and CSR side inputs
  input  logic [XLEN-1:0]    irq_i,
  input  logic               mie_we_i,
  input  logic [XLEN-1:0]    mie_wdata_i,
  input  logic               mret_i,

  // Buffer read strobe
  output logic               pop_o,

  // Registered completion pulses
  output logic               retire_o,
  output logic [XLEN-1:0]    retire_pc_o,
  output logic               trap_o,
  output logic               irq_ack_o,

  // CSR state
  output logic [XLEN-1:0]    mepc_o,
  output logic [XLEN-1:0]    mcause_o,
  output logic               mstatus_mie_o
);

  logic [XLEN-1:0]    mie_q;
  logic [XLEN-1:0]    irq_pend;
  logic [CAUSE_W-1:0] irq_idx;
  logic               take_irq;
  logic               take_exc;
  logic               take_ret;

  //////////////////////////////////////////////////////////////
  // Decision on the head entry
  //////////////////////////////////////////////////////////////

  assign irq_pend = irq_i & mie_q;

  // Interrupts are only taken in front of a valid head, whose PC becomes MEPC
  assign take_irq = head_valid_i && mstatus_mie_o && (|irq_pend);

  // The head leaves the buffer only when no interrupt claims this cycle
  assign pop_o    = head_valid_i && !take_irq;
  assign take_exc = pop_o && head_exc_i;
  assign take_ret = pop_o && !head_exc_i;

  // Lowest pending enabled line wins
  always_comb begin
    irq_idx = '0;
    for (int i = XLEN - 1; i >= 0; i--) begin
      if (irq_pend[i]) begin
        irq_idx = CAUSE_W'(i);
      end
    end
  end

  //////////////////////////////////////////////////////////////
  // CSR state and output pulses
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      trap_o        <= 1'b0;
      retire_o      <= 1'b0;
      irq_ack_o     <= 1'b0;
      mepc_o        <= '0;
      mcause_o      <= '0;
      mstatus_mie_o <= 1'b0;
      mie_q         <= '0;
    end else begin
      trap_o    <= take_irq || take_exc;
      retire_o  <= take_ret;
      irq_ack_o <= take_irq;

      if (take_irq || take_exc) begin
        mepc_o <= head_pc_i;
      end

      // Interrupt flag in the top bit, code or line index at the bottom
      if (take_irq) begin
        mcause_o <= {1'b1, {MCAUSE_PAD_W{1'b0}}, irq_idx};
      end else if (take_exc) begin
        mcause_o <= {1'b0, {MCAUSE_PAD_W{1'b0}}, head_cause_i};
      end

      // MRET in the same cycle as a trap leaves interrupts enabled
      if (mret_i) begin
        mstatus_mie_o <= 1'b1;
      end else if (take_irq || take_exc) begin
        mstatus_mie_o <= 1'b0;
      end

      // A write in the decision cycle only affects later decisions
      if (mie_we_i) begin
        mie_q <= mie_wdata_i;
      end
    end
  end

  // PC of the retiring instruction travels with the retire pulse
  always_ff @(posedge clk) begin
    if (take_ret) begin
      retire_pc_o <= head_pc_i;
    end
  end

endmodule

`default_nettype wire

//--- design/trap_sva.sv
// Trap unit checker
`default_nettype none

module trap_sva
  import trap_pkg::*;
(
  input logic            clk,
  input logic            rst_ni,

  // Top level stimulus side
  input logic            in_valid_i,
  input logic [XLEN-1:0] in_pc_i,
  input logic            in_mpu_err_i,
  input logic            in_bus_err_i,
  input logic            in_illegal_i,
  input logic            in_ecall_i,
  input logic            in_ebrk_i,
  input logic            full_o,
  input logic [XLEN-1:0] irq_i,
  input logic [XLEN-1:0] mie_wdata_i,
  input logic            mie_we_i,
  input logic            mret_i,

  // Probed trap CSR outputs
  input logic            trap_o,
  input logic            irq_ack_o,
  input logic            retire_o,
  input logic [XLEN-1:0] mepc_o,
  input logic [XLEN-1:0] mcause_o,
  input logic            mstatus_mie_o
);

  logic [XLEN-1:0]    mie_shadow_q;
  logic [XLEN-1:0]    pend_prev_q;
  logic [CAUSE_W-1:0] ack_idx;
  logic [CAUSE_W-1:0] in_cause;
  logic               in_fault;
  logic               accept;

  assign in_cause = exc_cause(exc_flags(in_mpu_err_i, in_bus_err_i, in_illegal_i,
                                        in_ecall_i, in_ebrk_i));
  assign in_fault = (in_cause != '0);
  assign accept   = in_valid_i && !full_o;
  assign ack_idx  = mcause_o[CAUSE_W-1:0];

  // Shadow of MIE and the enabled pending lines seen by the last decision
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mie_shadow_q <= '0;
      pend_prev_q  <= '0;
    end else begin
      pend_prev_q <= irq_i & mie_shadow_q;
      if (mie_we_i) begin
        mie_shadow_q <= mie_wdata_i;
      end
    end
  end

  //////////////////////////////////////////////////////////////
  // Interrupt and pulse checks
  //////////////////////////////////////////////////////////////

  // Reported line was enabled and pending, and no lower one was
  a_irq_enabled :
    assert property (@(posedge clk) disable iff (!rst_ni)
                     irq_ack_o |-> (mcause_o[XLEN-1] && pend_prev_q[ack_idx] &&
                     ((pend_prev_q & ((XLEN'(1) << ack_idx) - XLEN'(1))) == '0)))
      else $error("trap_sva: interrupt taken on a disabled or non-pending line");

  // Taking a trap masks interrupts unless an MRET landed on the same edge
  a_mie_cleared :
    assert property (@(posedge clk) disable iff (!rst_ni)
                     trap_o |-> (!mstatus_mie_o || $past(mret_i)))
      else $error("trap_sva: MSTATUS.MIE still set during trap");

  a_trap_retire_excl :
    assert property (@(posedge clk) disable iff (!rst_ni) !(trap_o && retire_o))
      else $error("trap_sva: trap and retire in the same cycle");

  //////////////////////////////////////////////////////////////
  // First occurrence MEPC tracking, one slot per cause
  //////////////////////////////////////////////////////////////

  for (genvar k = 0; k < NUM_EXC; k++) begin : g_first
    logic            exp_found_q;
    logic            act_found_q;
    logic [XLEN-1:0] exp_pc_q;
    logic [XLEN-1:0] act_pc_q;
    logic            exp_hit;
    logic            act_hit;

    // First accepted input resolving to this cause
    assign exp_hit = !exp_found_q && accept && in_fault && (in_cause == EXC_PRIO_CODE[k]);

    // First exception trap reporting this cause, interrupts are ignored
    assign act_hit = !act_found_q && trap_o && !irq_ack_o && !mcause_o[XLEN-1] &&
                     (mcause_o[MCAUSE_PAD_W+CAUSE_W-1:CAUSE_W] == '0) &&
                     (mcause_o[CAUSE_W-1:0] == EXC_PRIO_CODE[k]);

    always_ff @(posedge clk or negedge rst_ni) begin
      if (!rst_ni) begin
        exp_found_q <= 1'b0;
        act_found_q <= 1'b0;
      end else begin
        exp_found_q <= exp_found_q || exp_hit;
        act_found_q <= act_found_q || act_hit;
      end
    end

    always_ff @(posedge clk) begin
      if (exp_hit) begin
        exp_pc_q <= in_pc_i;
      end
      if (act_hit) begin
        act_pc_q <= mepc_o;
      end
    end

    a_first_mepc :
      assert property (@(posedge clk) disable iff (!rst_ni)
                       (exp_found_q && act_found_q) |-> (exp_pc_q == act_pc_q))
        else $error("trap_sva: first MEPC mismatch for cause %0d", EXC_PRIO_CODE[k]);
  end

endmodule

`default_nettype wire

//--- design/trap_top.sv
// Trap unit top level
`default_nettype none

module trap_top
  import trap_pkg::*;
(
  input  logic            clk,
  input  logic            rst_ni,

  // Retirement stream
  input  logic            in_valid_i,
  input  logic [XLEN-1:0] in_pc_i,
  input  logic            in_mpu_err_i,
  input  logic            in_bus_err_i,
  input  logic            in_illegal_i,
  input  logic            in_ecall_i,
  input  logic            in_ebrk_i,

  // Interrupts and CSR access
  input  logic [XLEN-1:0] irq_i,
  input  logic            mie_we_i,
  input  logic [XLEN-1:0] mie_wdata_i,
  input  logic            mret_i,

  output logic            full_o,
  output logic            retire_o,
  output logic [XLEN-1:0] retire_pc_o,
  output logic            trap_o,
  output logic [XLEN-1:0] mepc_o,
  output logic [XLEN-1:0] mcause_o,
  output logic            mstatus_mie_o,
  output logic            irq_ack_o
);

  // Producer to buffer
  logic               push;
  logic [XLEN-1:0]    push_pc;
  logic               push_exc;
  logic [CAUSE_W-1:0] push_cause;

  // Buffer to consumer
  logic               head_valid;
  logic [XLEN-1:0]    head_pc;
  logic               head_exc;
  logic [CAUSE_W-1:0] head_cause;
  logic               pop;

  retire_decode decode_i (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .in_valid_i   (in_valid_i),
    .in_pc_i      (in_pc_i),
    .in_mpu_err_i (in_mpu_err_i),
    .in_bus_err_i (in_bus_err_i),
    .in_illegal_i (in_illegal_i),
    .in_ecall_i   (in_ecall_i),
    .in_ebrk_i    (in_ebrk_i),
    .full_i       (full_o),
    .push_o       (push),
    .push_pc_o    (push_pc),
    .push_exc_o   (push_exc),
    .push_cause_o (push_cause)
  );

  retire_fifo fifo_i (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .push_i       (push),
    .push_pc_i    (push_pc),
    .push_exc_i   (push_exc),
    .push_cause_i (push_cause),
    .pop_i        (pop),
    .full_o       (full_o),
    .head_valid_o (head_valid),
    .head_pc_o    (head_pc),
    .head_exc_o   (head_exc),
    .head_cause_o (head_cause)
  );

  trap_csr csr_i (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .head_valid_i  (head_valid),
    .head_pc_i     (head_pc),
    .head_exc_i    (head_exc),
    .head_cause_i  (head_cause),
    .irq_i         (irq_i),
    .mie_we_i      (mie_we_i),
    .mie_wdata_i   (mie_wdata_i),
    .mret_i        (mret_i),
    .pop_o         (pop),
    .retire_o      (retire_o),
    .retire_pc_o   (retire_pc_o),
    .trap_o        (trap_o),
    .irq_ack_o     (irq_ack_o),
    .mepc_o        (mepc_o),
    .mcause_o      (mcause_o),
    .mstatus_mie_o (mstatus_mie_o)
  );

  // Checker only observes, it drives nothing back
  trap_sva sva_i (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .in_valid_i    (in_valid_i),
    .in_pc_i       (in_pc_i),
    .in_mpu_err_i  (in_mpu_err_i),
    .in_bus_err_i  (in_bus_err_i),
    .in_illegal_i  (in_illegal_i),
    .in_ecall_i    (in_ecall_i),
    .in_ebrk_i     (in_ebrk_i),
    .full_o        (full_o),
    .irq_i         (irq_i),
    .mie_wdata_i   (mie_wdata_i),
    .mie_we_i      (mie_we_i),
    .mret_i        (mret_i),
    .trap_o        (trap_o),
    .irq_ack_o     (irq_ack_o),
    .retire_o      (retire_o),
    .mepc_o        (mepc_o),
    .mcause_o      (mcause_o),
    .mstatus_mie_o (mstatus_mie_o)
  );

endmodule

`default_nettype wire

//--- sim/trap_tb.sv
// Trap unit testbench
`default_nettype none

module trap_tb
  import trap_pkg::*;
();

  localparam int TIMEOUT = 200;

  logic            clk;
  logic            rst_ni;
  logic            in_valid;
  logic [XLEN-1:0] in_pc;
  // Fault flags ordered {mpu, bus, illegal, ecall, ebrk}
  logic [4:0]      in_flags;
  logic [XLEN-1:0] irq;
  logic            mie_we;
  logic [XLEN-1:0] mie_wdata;
  logic            mret;
  logic            full;
  logic            retire;
  logic [XLEN-1:0] retire_pc;
  logic            trap;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcause;
  logic            mstatus_mie;
  logic            irq_ack;

  // Outstanding instructions, each entry is {fault, cause, pc}
  logic [XLEN+CAUSE_W:0] model_q [$];
  logic [XLEN-1:0]       mie_model;
  logic [XLEN-1:0]       pend_prev;
  logic                  mst_model;
  logic                  mst_dec;
  logic                  mret_prev;
  int                    seed;
  int                    err_cnt;
  int                    test_err_start;
  int                    tests_pass;
  int                    tests_fail;
  int                    n_ret;
  int                    n_trap;
  int                    n_ack;
  bit                    hung;
  string                 cur_test;

  trap_top dut_i (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .in_valid_i    (in_valid),
    .in_pc_i       (in_pc),
    .in_mpu_err_i  (in_flags[4]),
    .in_bus_err_i  (in_flags[3]),
    .in_illegal_i  (in_flags[2]),
    .in_ecall_i    (in_flags[1]),
    .in_ebrk_i     (in_flags[0]),
    .irq_i         (irq),
    .mie_we_i      (mie_we),
    .mie_wdata_i   (mie_wdata),
    .mret_i        (mret),
    .full_o        (full),
    .retire_o      (retire),
    .retire_pc_o   (retire_pc),
    .trap_o        (trap),
    .mepc_o        (mepc),
    .mcause_o      (mcause),
    .mstatus_mie_o (mstatus_mie),
    .irq_ack_o     (irq_ack)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////

  // MPU fault first, then bus fault, illegal, ECALL and EBREAK last
  function automatic logic [CAUSE_W-1:0] prio_cause(input logic [4:0] f);
    if (f[4]) return EXC_CAUSE_INSTR_FAULT;
    if (f[3]) return EXC_CAUSE_INSTR_BUS_FAULT;
    if (f[2]) return EXC_CAUSE_ILLEGAL_INSN;
    if (f[1]) return EXC_CAUSE_ECALL_MMODE;
    if (f[0]) return EXC_CAUSE_BREAKPOINT;
    return '0;
  endfunction

  // Index of the lowest set line, or -1 when none is set
  function automatic int lowest_line(input logic [XLEN-1:0] v);
    int idx;
    idx = -1;
    for (int i = 0; i < XLEN; i++) begin
      if (v[i] && idx < 0) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  task automatic value_error(input string what, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] act);
    $display("** Error [%s] %s: expected 0x%08h, actual 0x%08h", cur_test, what, exp, act);
    err_cnt++;
  endtask

  task automatic fail_note(input string what);
    $display("Error [%s]: %s", cur_test, what);
    err_cnt++;
  endtask

  // Samples the outputs on each edge, they settled during the cycle before
  always @(posedge clk) begin : monitor
    logic [XLEN+CAUSE_W:0] ent;
    logic [XLEN-1:0]       exp_val;
    int                    idx;
    if (!rst_ni) begin
      mie_model = '0;
      pend_prev = '0;
      mst_model = 1'b0;
      mst_dec   = 1'b0;
      mret_prev = 1'b0;
    end else begin
      // An MRET wins over the clearing by a trap decided on the same edge
      if (mret_prev) begin
        mst_model = 1'b1;
      end else if (trap) begin
        mst_model = 1'b0;
      end
      assert (mstatus_mie == mst_model)
        else value_error("mstatus_mie", XLEN'(mst_model), XLEN'(mstatus_mie));
      if (irq_ack) begin
        n_ack++;
        idx = lowest_line(pend_prev);
        assert (mst_dec && idx >= 0)
          else fail_note("interrupt acknowledged while masked or with no enabled line pending");
        assert (trap) else fail_note("interrupt acknowledged without a trap pulse");
        exp_val = {1'b1, {(XLEN-CAUSE_W-1){1'b0}}, idx[CAUSE_W-1:0]};
        assert (mcause == exp_val) else value_error("interrupt mcause", exp_val, mcause);
        // The interrupted instruction stays queued and completes later
        if (model_q.size() == 0) begin
          fail_note("interrupt taken with no instruction outstanding");
        end else begin
          assert (mepc == model_q[0][XLEN-1:0])
            else value_error("interrupt mepc", model_q[0][XLEN-1:0], mepc);
        end
      end else if (trap) begin
        n_trap++;
        if (model_q.size() == 0) begin
          fail_note("trap with no instruction outstanding");
        end else begin
          ent = model_q.pop_front();
          assert (ent[XLEN+CAUSE_W]) else fail_note("trap taken on a clean instruction");
          assert (mepc == ent[XLEN-1:0]) else value_error("exception mepc", ent[XLEN-1:0], mepc);
          exp_val = {1'b0, {(XLEN-CAUSE_W-1){1'b0}}, ent[XLEN+CAUSE_W-1:XLEN]};
          assert (mcause == exp_val) else value_error("exception mcause", exp_val, mcause);
        end
      end
      if (retire) begin
        n_ret++;
        if (model_q.size() == 0) begin
          fail_note("retire with no instruction outstanding");
        end else begin
          ent = model_q.pop_front();
          assert (!ent[XLEN+CAUSE_W]) else fail_note("faulting instruction retired");
          assert (retire_pc == ent[XLEN-1:0])
            else value_error("retire pc", ent[XLEN-1:0], retire_pc);
        end
      end
      // Inputs seen by the DUT on this edge, checked against the next pulses
      mst_dec   = mst_model;
      pend_prev = irq & mie_model;
      if (mie_we) mie_model = mie_wdata;
      mret_prev = mret;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // One cycle of input, a strobe only goes out while the buffer has room
  task automatic drive_cycle(input bit want, input logic [XLEN-1:0] pc,
                             input logic [4:0] flags, output bit sent);
    sent     = want && !full;
    in_valid = sent;
    in_pc    = pc;
    in_flags = flags;
    if (sent) model_q.push_back({|flags, prio_cause(flags), pc});
    idle(1);
    in_valid = 1'b0;
  endtask

  task automatic send_instr(input logic [XLEN-1:0] pc, input logic [4:0] flags);
    bit sent;
    int waited;
    sent   = 1'b0;
    waited = 0;
    while (!sent && !hung) begin
      drive_cycle(1'b1, pc, flags, sent);
      waited++;
      if (!sent && waited >= TIMEOUT) begin
        fail_note("full level never dropped");
        hung = 1'b1;
      end
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (model_q.size() != 0 && !hung) begin
      idle(1);
      waited++;
      if (waited >= TIMEOUT && model_q.size() != 0) begin
        fail_note("timed out waiting for outstanding instructions");
        hung = 1'b1;
      end
    end
    // A few quiet cycles so a stray pulse still shows up
    idle(4);
  endtask

  task automatic write_mie(input logic [XLEN-1:0] val);
    mie_we    = 1'b1;
    mie_wdata = val;
    idle(1);
    mie_we    = 1'b0;
  endtask

  task automatic pulse_mret();
    mret = 1'b1;
    idle(1);
    mret = 1'b0;
  endtask

  task automatic start_test(input string name);
    cur_test       = name;
    test_err_start = err_cnt;
    n_ret          = 0;
    n_trap         = 0;
    n_ack          = 0;
  endtask

  task automatic end_test();
    if (err_cnt == test_err_start) begin
      $display("test %s: ok", cur_test);
      tests_pass++;
    end else begin
      $display("test %s: %0d errors", cur_test, err_cnt - test_err_start);
      tests_fail++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic reset_state();
    start_test("reset");
    assert (!retire && !trap && !irq_ack) else fail_note("a pulse is high after reset");
    assert (!full) else fail_note("full level is high after reset");
    assert (mepc == '0) else value_error("mepc", '0, mepc);
    assert (mcause == '0) else value_error("mcause", '0, mcause);
    assert (!mstatus_mie) else value_error("mstatus_mie", '0, XLEN'(mstatus_mie));
    end_test();
  endtask

  task automatic retire_in_order();
    start_test("retire_order");
    irq = '0;
    for (int i = 0; i < 200; i++) send_instr($random(seed), 5'b0);
    wait_drain();
    assert (n_ret == 200) else value_error("retire count", 200, n_ret);
    assert (n_trap == 0) else value_error("trap count", 0, n_trap);
    end_test();
  endtask

  task automatic exception_priority();
    logic [4:0] f;
    start_test("exception_priority");
    // Interrupts enabled first, so the first trap has something to clear
    pulse_mret();
    for (int i = 0; i < 60; i++) begin
      f = 5'($random(seed));
      if (f == '0) f = 5'b00100;
      send_instr($random(seed), f);
    end
    wait_drain();
    assert (n_trap == 60) else value_error("trap count", 60, n_trap);
    assert (n_ret == 0) else value_error("retire count", 0, n_ret);
    assert (!mstatus_mie) else value_error("mstatus_mie", '0, XLEN'(mstatus_mie));
    end_test();
  endtask

  task automatic irq_entry();
    logic [4:0] f;
    start_test("interrupts");
    pulse_mret();
    write_mie($random(seed));
    for (int i = 0; i < 80; i++) begin
      irq = $random(seed);
      // An occasional MRET reopens interrupts after a trap
      if (($random(seed) & 3) == 0) begin
        pulse_mret();
      end
      f = (($random(seed) & 7) == 0) ? 5'($random(seed)) : 5'b0;
      send_instr($random(seed), f);
    end
    irq = '0;
    wait_drain();
    assert (n_ack > 0) else fail_note("no interrupt was taken");
    assert (n_ret + n_trap == 80) else value_error("completed count", 80, n_ret + n_trap);
    end_test();
  endtask

  task automatic masked_irqs();
    start_test("masking");
    irq = '0;
    write_mie('0);
    pulse_mret();
    // MSTATUS.MIE set but every line disabled
    for (int i = 0; i < 30; i++) begin
      irq = $random(seed);
      send_instr($random(seed), 5'b0);
    end
    irq = '0;
    // The ECALL trap clears MSTATUS.MIE before the lines are enabled
    send_instr($random(seed), 5'b00010);
    wait_drain();
    write_mie('1);
    for (int i = 0; i < 30; i++) begin
      irq = $random(seed);
      send_instr($random(seed), 5'b0);
    end
    irq = '0;
    wait_drain();
    assert (n_ack == 0) else value_error("interrupt count", 0, n_ack);
    assert (n_ret == 60) else value_error("retire count", 60, n_ret);
    assert (n_trap == 1) else value_error("trap count", 1, n_trap);
    end_test();
  endtask

  task automatic fill_buffer();
    bit sent;
    bit full_seen;
    int accepted;
    start_test("backpressure");
    full_seen = 1'b0;
    accepted  = 0;
    write_mie(32'h1);
    // Held MRET keeps line 0 taken every cycle, so the head never pops
    irq  = 32'h1;
    mret = 1'b1;
    for (int i = 0; i < 12; i++) begin
      if (full) full_seen = 1'b1;
      drive_cycle(1'b1, $random(seed), 5'b0, sent);
      if (sent) accepted++;
    end
    mret = 1'b0;
    irq  = '0;
    wait_drain();
    assert (full_seen) else fail_note("full level never rose during the burst");
    assert (n_ret == accepted) else value_error("retire count", accepted, n_ret);
    assert (n_trap == 0) else value_error("exception count", 0, n_trap);
    end_test();
  endtask

  initial begin
    seed       = 32'h80ab197e;
    err_cnt    = 0;
    tests_pass = 0;
    tests_fail = 0;
    hung       = 1'b0;
    cur_test   = "setup";
    rst_ni     = 1'b0;
    in_valid   = 1'b0;
    in_pc      = '0;
    in_flags   = '0;
    irq        = '0;
    mie_we     = 1'b0;
    mie_wdata  = '0;
    mret       = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_ni = 1'b1;
    reset_state();
    retire_in_order();
    exception_priority();
    irq_entry();
    masked_irqs();
    fill_buffer();
    $display("tests passed: %0d, tests failed: %0d", tests_pass, tests_fail);
    if (tests_fail == 0 && err_cnt == 0 && !hung) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
design/trap_pkg.sv
design/retire_decode.sv
design/retire_fifo.sv
design/trap_csr.sv
design/trap_sva.sv
design/trap_top.sv
sim/trap_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the trap unit testbench with Verilator and runs it.
# The run counts as passed only if the log holds the pass message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --top-module trap_tb -f build.f -o trap_sim \
  && ./obj_dir/trap_sim > "$LOG" 2>&1 \
  || echo "build or simulation did not complete" >&2

cat "$LOG" 2>/dev/null

grep -q "SIMULATION PASSED" "$LOG" 2>/dev/null && exit 0 || exit 1
